// ==== compile.f ====
+incdir+verif
common/memPkg.sv
hdl/byteRam.sv
hdl/ioOutFifo.sv
memctrl/memCtrl.sv
hdl/memSubsys.sv
verif/tbMemSubsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tbMemSubsys -o tbMemSubsys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tbMemSubsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
exit 1

// ==== verif/tbChecks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam logic [31:0] SEED = 32'd67226;

int passCount = 0;
int failCount = 0;
logic [31:0] rngMain = SEED;
// separate stream for the ready levels
logic [31:0] rngLevel = ~SEED;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] randMain();
    rngMain = xorshift32(rngMain);
    return rngMain;
endfunction

// one of the legal lengths 1, 2, 4
function automatic lenT randLen();
    return lenT'(1 << (randMain() % 3));
endfunction

task automatic checkWord(input string name, input wordT expected, input wordT actual);
    if (actual === expected) begin
        passCount++;
        $display("PASS %s 0x%08h", name, actual);
    end else begin
        failCount++;
        $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
    end
endtask

task automatic checkByte(input string name, input byteT expected, input byteT actual);
    if (actual === expected) begin
        passCount++;
        $display("PASS %s 0x%02h", name, actual);
    end else begin
        failCount++;
        $display("FAIL %s expected 0x%02h actual 0x%02h", name, expected, actual);
    end
endtask

task automatic reportProblem(input string msg);
    failCount++;
    $display("ERROR: %s", msg);
endtask

`endif

// ==== verif/tbMemSubsys.sv ====
`timescale 1ns/1ps

module tbMemSubsys import memPkg::*; ();

    localparam addrT REGION_BASE = 18'h00100;
    localparam int REGION_SIZE = 256;
    localparam int NUM_PAIRS = 40;
    localparam int NUM_FETCH = 30;
    localparam int NUM_ARB = 10;
    localparam int NUM_IO = 20;
    localparam int NUM_TXN = 2 * NUM_PAIRS + REGION_SIZE / 4 + NUM_FETCH + 2 * NUM_ARB
                             + NUM_IO + 3;
    // word access plus acceptance and the idle gap
    localparam int WORST_CYCLES = 6;

    logic clk = 1'b0;
    logic rst;
    logic i_rdy;
    logic i_infEn;
    addrT i_infAddr;
    logic i_dcEn;
    logic i_dcStore;
    lenT  i_dcLen;
    addrT i_dcAddr;
    wordT i_dcData;
    logic i_ioReady;
    logic o_infDone;
    wordT o_infInst;
    logic o_dcDone;
    wordT o_dcData;
    logic o_ioValid;
    byteT o_ioByte;

    byteT shadow [RAM_DEPTH];
    byteT ioModel [$];
    wordT dcGot;
    wordT infGot;
    logic rdyRandom = 1'b0;
    int ioLowLeft = 0;
    int infIssued = 0;
    int dcIssued = 0;
    int infDoneCount = 0;
    int dcDoneCount = 0;

    memSubsys u_memSubsys (.*);

    `include "tbChecks.svh"

    always #10 clk = ~clk;

    // ready levels with long low stretches on the output drain
    always @(negedge clk) begin
        rngLevel = xorshift32(rngLevel);
        i_rdy = !rdyRandom || (rngLevel[1:0] != 2'b00);
        i_ioReady = (ioLowLeft == 0) && rngLevel[5];
        if (ioLowLeft != 0) begin
            ioLowLeft--;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if ((o_infDone || o_dcDone) && !i_rdy) begin
                reportProblem("done pulse while i_rdy was low");
            end
            infDoneCount += int'(o_infDone);
            dcDoneCount += int'(o_dcDone);
            if (o_ioValid && i_ioReady) begin
                if (ioModel.size() == 0) begin
                    reportProblem("output port drained a byte that was never stored");
                end else begin
                    checkByte("ioDrain", ioModel.pop_front(), o_ioByte);
                end
            end
        end
    end

    // little-endian and zero-extended
    function automatic wordT modelLoad(input addrT addr, input lenT len);
        wordT w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[8*i +: 8] = shadow[RAM_ADDR_WIDTH'(addr + addrT'(i))];
        end
        return w;
    endfunction

    function automatic void modelStore(input addrT addr, input lenT len, input wordT data);
        for (int i = 0; i < int'(len); i++) begin
            shadow[RAM_ADDR_WIDTH'(addr + addrT'(i))] = data[8*i +: 8];
        end
    endfunction

    // raise the enables together and drop each after its done pulse
    task automatic issue(input logic useDc, input logic useInf);
        logic dcSeen;
        logic infSeen;
        dcSeen = !useDc;
        infSeen = !useInf;
        dcIssued += int'(useDc);
        infIssued += int'(useInf);
        @(negedge clk);
        i_dcEn = useDc;
        i_infEn = useInf;
        while (!(dcSeen && infSeen)) begin
            @(posedge clk);
            if (o_infDone && useInf) begin
                if (!dcSeen) begin
                    reportProblem("fetch finished before the waiting data request");
                end
                infSeen = 1'b1;
                infGot = o_infInst;
            end
            if (o_dcDone && useDc) begin
                dcSeen = 1'b1;
                dcGot = o_dcData;
            end
            @(negedge clk);
            i_dcEn = i_dcEn && !dcSeen;
            i_infEn = i_infEn && !infSeen;
        end
    endtask

    task automatic storeData(input addrT addr, input lenT len, input wordT data);
        i_dcStore = 1'b1;
        i_dcAddr = addr;
        i_dcLen = len;
        i_dcData = data;
        issue(1'b1, 1'b0);
        if (addr == IO_ADDR) begin
            ioModel.push_back(data[7:0]);
        end else begin
            modelStore(addr, len, data);
        end
    endtask

    task automatic loadData(input string name, input addrT addr, input lenT len);
        i_dcStore = 1'b0;
        i_dcAddr = addr;
        i_dcLen = len;
        issue(1'b1, 1'b0);
        checkWord(name, modelLoad(addr, len), dcGot);
    endtask

    task automatic fetchInst(input string name, input addrT addr);
        i_infAddr = addr;
        issue(1'b0, 1'b1);
        checkWord(name, modelLoad(addr, LEN_WORD), infGot);
    endtask

    initial begin
        addrT a;
        lenT len;
        lenT loadLen;
        wordT d;
        logic [2:0] quiet;
        rst = 1'b1;
        i_rdy = 1'b1;
        i_infEn = 1'b0;
        i_infAddr = '0;
        i_dcEn = 1'b0;
        i_dcStore = 1'b0;
        i_dcLen = LEN_WORD;
        i_dcAddr = '0;
        i_dcData = '0;
        i_ioReady = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        quiet = '0;
        repeat (5) begin
            @(posedge clk);
            quiet = quiet | {o_infDone, o_dcDone, o_ioValid};
        end
        checkWord("resetQuiet", '0, wordT'(quiet));
        @(negedge clk);

        // second half runs with i_rdy toggling
        for (int n = 0; n < NUM_PAIRS; n++) begin
            rdyRandom = (n >= NUM_PAIRS / 2);
            len = randLen();
            a = REGION_BASE + addrT'(randMain() % (REGION_SIZE - len + 1));
            storeData(a, len, randMain());
            loadLen = randLen();
            while (loadLen > len) begin
                loadLen = randLen();
            end
            a = a + addrT'(randMain() % (len - loadLen + 1));
            loadData($sformatf("load%0d", n), a, loadLen);
        end

        for (int n = 0; n < REGION_SIZE / 4; n++) begin
            storeData(REGION_BASE + addrT'(4 * n), LEN_WORD, randMain());
        end
        for (int n = 0; n < NUM_FETCH; n++) begin
            a = REGION_BASE + addrT'(randMain() % (REGION_SIZE - 3));
            fetchInst($sformatf("fetch%0d", n), a);
        end

        // both requesters in the same idle cycle
        for (int n = 0; n < NUM_ARB; n++) begin
            len = randLen();
            d = randMain();
            a = REGION_BASE + addrT'(randMain() % (REGION_SIZE - 3));
            i_infAddr = REGION_BASE + addrT'(randMain() % (REGION_SIZE - 3));
            i_dcStore = d[0];
            i_dcAddr = a;
            i_dcLen = len;
            i_dcData = d;
            issue(1'b1, 1'b1);
            if (d[0]) begin
                modelStore(a, len, d);
            end else begin
                checkWord($sformatf("arbLoad%0d", n), modelLoad(a, len), dcGot);
            end
            checkWord($sformatf("arbFetch%0d", n), modelLoad(i_infAddr, LEN_WORD), infGot);
        end

        // word at 0 shares its RAM index with IO_ADDR
        storeData('0, LEN_WORD, randMain());
        for (int n = 0; n < NUM_IO; n++) begin
            if (n % 10 == 0) begin
                ioLowLeft = 40;
            end
            storeData(IO_ADDR, LEN_BYTE, randMain());
            // eight bytes stored while the drain is still held off
            if (n == 7) begin
                loadData("loadBehindFifo", REGION_BASE, LEN_WORD);
            end
        end
        loadData("ramUnderIo", '0, LEN_WORD);
        while (ioModel.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        if (o_ioValid) begin
            reportProblem("output FIFO still holds bytes after all stored bytes drained");
        end
        checkWord("fetchDoneCount", wordT'(infIssued), wordT'(infDoneCount));
        checkWord("dataDoneCount", wordT'(dcIssued), wordT'(dcDoneCount));

        $display("checks: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TXN * 4 * WORST_CYCLES + 200) @(posedge clk);
        $display("ERROR: watchdog expired before all requests completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== hdl/memSubsys.sv ====
`timescale 1ns/1ps

module memSubsys import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_rdy,

    input  logic i_infEn,
    input  addrT i_infAddr,

    input  logic i_dcEn,
    input  logic i_dcStore,
    input  lenT  i_dcLen,
    input  addrT i_dcAddr,
    input  wordT i_dcData,

    input  logic i_ioReady,

    output logic o_infDone,
    output wordT o_infInst,
    output logic o_dcDone,
    output wordT o_dcData,
    output logic o_ioValid,
    output byteT o_ioByte
);

    addrT ramAddr;
    logic ramWr;
    byteT ramWrByte;
    byteT ramRdByte;

    logic ioPush;
    byteT ioPushByte;
    logic ioFull;

    memCtrl u_memCtrl (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_ioFull     (ioFull),
        .i_infEn      (i_infEn),
        .i_infAddr    (i_infAddr),
        .i_dcEn       (i_dcEn),
        .i_dcStore    (i_dcStore),
        .i_dcLen      (i_dcLen),
        .i_dcAddr     (i_dcAddr),
        .i_dcData     (i_dcData),
        .i_ramRdByte  (ramRdByte),
        .o_ramAddr    (ramAddr),
        .o_ramWr      (ramWr),
        .o_ramWrByte  (ramWrByte),
        .o_ioPush     (ioPush),
        .o_ioPushByte (ioPushByte),
        .o_infDone    (o_infDone),
        .o_infInst    (o_infInst),
        .o_dcDone     (o_dcDone),
        .o_dcData     (o_dcData)
    );

    byteRam u_byteRam (
        .clk      (clk),
        .i_addr   (ramAddr),
        .i_wr     (ramWr),
        .i_wrByte (ramWrByte),
        .o_rdByte (ramRdByte)
    );

    // output port, drained by the outside through i_ioReady
    ioOutFifo u_ioOutFifo (
        .clk        (clk),
        .rst        (rst),
        .i_push     (ioPush),
        .i_pushByte (ioPushByte),
        .i_ready    (i_ioReady),
        .o_full     (ioFull),
        .o_valid    (o_ioValid),
        .o_headByte (o_ioByte)
    );

endmodule

// ==== memctrl/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_rdy,
    input  logic i_ioFull,

    // fetch requester
    input  logic i_infEn,
    input  addrT i_infAddr,

    // data requester
    input  logic i_dcEn,
    input  logic i_dcStore,
    input  lenT  i_dcLen,
    input  addrT i_dcAddr,
    input  wordT i_dcData,

    // byte RAM
    input  byteT i_ramRdByte,
    output addrT o_ramAddr,
    output logic o_ramWr,
    output byteT o_ramWrByte,

    // output port FIFO
    output logic o_ioPush,
    output byteT o_ioPushByte,

    // results
    output logic o_infDone,
    output wordT o_infInst,
    output logic o_dcDone,
    output wordT o_dcData
);

    ctrlStateT state;
    stageT     stage;

    addrT addrQ;
    lenT  lenQ;
    wordT dataQ;
    wordT asmQ;
    addrT lastAddr;

    logic stall;
    logic isRead;
    logic lastStage;
    logic ioStore;
    addrT curAddr;
    wordT fullWord;
    wordT asmWord;

    assign stall = !i_rdy || i_ioFull;

    assign isRead = (state == RInst) || (state == RData);

    // reads finish one stage later than writes because of the registered RAM port
    assign lastStage = isRead ? (stage == lenQ) : (stage == lenQ - 3'd1);

    // only single-byte stores are routed to the output port
    assign ioStore = (addrQ == IO_ADDR) && (lenQ == LEN_BYTE);

    assign curAddr = addrQ + addrT'(stage);

    // when stalled, re-present the previous address so the RAM keeps returning
    // the byte the next capture expects
    assign o_ramAddr = stall ? lastAddr : curAddr;

    always_ff @(posedge clk) begin
        lastAddr <= o_ramAddr;
    end

    // store path
    assign o_ramWr = !stall && (state == WData) && !ioStore;
    assign o_ramWrByte = dataQ[{stage[1:0], 3'b000} +: 8];

    assign o_ioPush = !stall && (state == WData) && ioStore;
    assign o_ioPushByte = dataQ[7:0];

    // incoming byte enters at the top, earlier bytes move down
    assign fullWord = {i_ramRdByte, asmQ[31:8]};

    // right-align short loads, zero fill from the top
    assign asmWord = fullWord >> {LEN_WORD - lenQ, 3'b000};

    assign o_infDone = !stall && (state == RInst) && lastStage;
    assign o_infInst = asmWord;

    assign o_dcDone = !stall && ((state == RData) || (state == WData)) && lastStage;
    assign o_dcData = asmWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            stage <= '0;
        end else if (!stall) begin
            case (state)
                Idle: begin
                    stage <= '0;
                    // data has priority over fetch
                    if (i_dcEn) begin
                        state <= i_dcStore ? WData : RData;
                    end else if (i_infEn) begin
                        state <= RInst;
                    end
                end
                default: begin
                    if (lastStage) begin
                        state <= Idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // request latch and byte assembly
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == Idle) begin
                if (i_dcEn) begin
                    addrQ <= i_dcAddr;
                    lenQ  <= i_dcLen;
                    dataQ <= i_dcData;
                end else if (i_infEn) begin
                    addrQ <= i_infAddr;
                    lenQ  <= LEN_WORD;
                end
            end else if (isRead && (stage != '0)) begin
                // stage 0 has no returned byte yet
                asmQ <= fullWord;
            end
        end
    end

endmodule

// ==== hdl/ioOutFifo.sv ====
`timescale 1ns/1ps

module ioOutFifo import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_push,
    input  byteT i_pushByte,
    input  logic i_ready,
    output logic o_full,
    output logic o_valid,
    output byteT o_headByte
);

    byteT buffer [IO_FIFO_DEPTH];

    logic [IO_FIFO_PTR_W-1:0] wrPtr;
    logic [IO_FIFO_PTR_W-1:0] rdPtr;
    logic [IO_FIFO_PTR_W:0]   count;

    logic doPush;
    logic doPop;

    assign o_full = (count == (IO_FIFO_PTR_W + 1)'(IO_FIFO_DEPTH));
    assign o_valid = (count != '0);
    assign o_headByte = buffer[rdPtr];

    // full blocks the push, the controller is stalled then anyway
    assign doPush = i_push && !o_full;
    assign doPop = i_ready && o_valid;

    always_ff @(posedge clk) begin
        if (doPush) begin
            buffer[wrPtr] <= i_pushByte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/byteRam.sv ====
`timescale 1ns/1ps

module byteRam import memPkg::*; (
    input  logic clk,
    input  addrT i_addr,
    input  logic i_wr,
    input  byteT i_wrByte,
    output byteT o_rdByte
);

    byteT mem [RAM_DEPTH];

    logic [RAM_ADDR_WIDTH-1:0] index;

    // upper address bits fold onto the low 4 KiB
    assign index = i_addr[RAM_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[index] <= i_wrByte;
        end
        // read data shows up one cycle later
        o_rdByte <= mem[index];
    end

endmodule

// ==== common/memPkg.sv ====
package memPkg;

    // byte address into the 18-bit memory map
    typedef logic [17:0] addrT;

    // memory and output port data
    typedef logic [7:0] byteT;

    // instruction and load/store data
    typedef logic [31:0] wordT;

    // access length in bytes, legal values 1, 2 and 4
    typedef logic [2:0] lenT;

    // byte counter inside one access
    typedef logic [2:0] stageT;

    typedef enum logic [1:0] {
        Idle,
        RInst,
        RData,
        WData
    } ctrlStateT;

    // memory-mapped output port
    localparam addrT IO_ADDR = 18'h30000;

    // 4 KiB of RAM, upper address bits ignored
    localparam int RAM_ADDR_WIDTH = 12;
    localparam int RAM_DEPTH = 2 ** RAM_ADDR_WIDTH;

    localparam int IO_FIFO_DEPTH = 8;
    localparam int IO_FIFO_PTR_W = $clog2(IO_FIFO_DEPTH);

    localparam lenT LEN_BYTE = 3'd1;
    localparam lenT LEN_WORD = 3'd4;

endpackage
